// File: fetch_pkg.sv
package fetch_pkg;

	// Address and data widths
	localparam int ADDR_W  = 32;
	localparam int INST_W  = 32;
	localparam int FLAGS_W = 6;   // MMU flags per instruction

	// Address queue geometry
	localparam int QUEUE_DEPTH = 8;
	localparam int QUEUE_PTR_W = 3;   // Depth is a power of two

	// One fetch group is two instruction words
	localparam int FETCH_STRIDE = 8;

	// Fetch address, always byte addressed
	typedef logic [ADDR_W-1:0] addr_t;

	// Single instruction word
	typedef logic [INST_W-1:0] inst_t;

	// Flag field returned by the MMU with each word
	typedef logic [FLAGS_W-1:0] mmu_flags_t;

endpackage

// File: fetch_addr_queue.sv
`timescale 1ns/1ps

module fetch_addr_queue #(
	parameter type payload_t = fetch_pkg::addr_t
) (
	input  logic     iCLOCK,
	input  logic     inRESET,
	input  logic     flush,
	input  logic     push,
	input  payload_t push_data,
	input  logic     pop,
	output payload_t head_data,
	output logic     full,
	output logic     empty
);
	import fetch_pkg::*;

	payload_t mem [QUEUE_DEPTH];

	logic [QUEUE_PTR_W-1:0] wr_ptr;
	logic [QUEUE_PTR_W-1:0] rd_ptr;
	logic [QUEUE_PTR_W:0]   count;   // One extra bit to tell full from empty

	logic do_push;
	logic do_pop;

	assign full  = (count == (QUEUE_PTR_W + 1)'(QUEUE_DEPTH));
	assign empty = (count == '0);

	assign do_pop  = pop && !empty;
	assign do_push = push && (!full || do_pop);   // Full queue still takes a push on a pop

	assign head_data = mem[rd_ptr];

	// Storage
	always_ff @(posedge iCLOCK) begin
		if (do_push && !flush) begin
			mem[wr_ptr] <= push_data;
		end
	end

	// Pointers wrap on their own since depth is a power of two
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else if (flush) begin
			wr_ptr <= '0;   // Drop everything in flight
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;   // Both or neither
			endcase
		end
	end

endmodule

// File: fetch_pc_gen.sv
`timescale 1ns/1ps

module fetch_pc_gen (
	input  logic             iCLOCK,
	input  logic             inRESET,
	input  logic             redirect,
	input  fetch_pkg::addr_t redirect_addr,
	input  logic             fetch_stall,
	input  logic             queue_full,
	output logic             fetch_req,
	output fetch_pkg::addr_t fetch_addr,
	output logic             push
);
	import fetch_pkg::*;

	typedef enum logic [1:0] {
		ST_START   = 2'd0,   // Reset start
		ST_FETCH   = 2'd1,   // Free running fetch
		ST_RESTART = 2'd2    // First group after a redirect
	} state_t;

	state_t state;
	logic   active;

	// Request only in an issuing state and when nothing pushes back
	assign active = (state == ST_FETCH) || (state == ST_RESTART);
	assign fetch_req = active && !redirect && !fetch_stall && !queue_full;

	// Memory takes every raised request
	assign push = fetch_req;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= ST_START;
			fetch_addr <= '0;
		end else if (redirect) begin
			// Restart at the group holding the target word
			state <= ST_RESTART;
			fetch_addr <= redirect_addr & ~ADDR_W'(FETCH_STRIDE - 1);
		end else begin
			case (state)
				ST_START: begin
					state <= ST_FETCH;
					fetch_addr <= '0;   // Boot address
				end
				ST_FETCH: begin
					if (push) begin
						fetch_addr <= fetch_addr + ADDR_W'(FETCH_STRIDE);
					end
				end
				ST_RESTART: begin
					// Leave once the restart group has been taken
					if (push) begin
						state <= ST_FETCH;
						fetch_addr <= fetch_addr + ADDR_W'(FETCH_STRIDE);
					end
				end
				default: begin
					state <= ST_START;
				end
			endcase
		end
	end

endmodule

// File: fetch_align.sv
`timescale 1ns/1ps

module fetch_align (
	input  logic                  iCLOCK,
	input  logic                  inRESET,
	input  logic                  redirect,
	input  fetch_pkg::addr_t      redirect_addr,
	input  logic                  resp0_valid,
	input  logic                  resp1_valid,
	input  fetch_pkg::inst_t      resp0_inst,
	input  fetch_pkg::inst_t      resp1_inst,
	input  fetch_pkg::mmu_flags_t resp0_flags,
	input  fetch_pkg::mmu_flags_t resp1_flags,
	input  fetch_pkg::addr_t      head_addr,
	input  logic                  dec_lock,
	output logic                  pop,
	output logic                  dec0_valid,
	output logic                  dec1_valid,
	output fetch_pkg::inst_t      dec0_inst,
	output fetch_pkg::inst_t      dec1_inst,
	output fetch_pkg::mmu_flags_t dec0_flags,
	output fetch_pkg::mmu_flags_t dec1_flags,
	output fetch_pkg::addr_t      dec_pc
);
	import fetch_pkg::*;

	logic skip;   // Next group starts at its upper word
	logic load;
	logic dec0_valid_q;
	logic dec1_valid_q;

	// A response is taken only when decode can accept it
	assign load = (resp0_valid || resp1_valid) && !dec_lock && !redirect;

	// Head address belongs to the response loaded this cycle
	assign pop = load;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			skip <= 1'b0;
		end else if (redirect) begin
			skip <= redirect_addr[2];   // Target in upper word of its group
		end else if (load) begin
			skip <= 1'b0;
		end
	end

	// Valid bits follow the response on every unlocked edge
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			dec0_valid_q <= 1'b0;
			dec1_valid_q <= 1'b0;
		end else if (redirect) begin
			dec0_valid_q <= 1'b0;
			dec1_valid_q <= 1'b0;
		end else if (!dec_lock) begin
			dec0_valid_q <= skip ? resp1_valid : resp0_valid;
			dec1_valid_q <= skip ? 1'b0 : resp1_valid;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (redirect) begin
			dec0_inst <= '0;
			dec0_flags <= '0;
			dec1_inst <= '0;
			dec1_flags <= '0;
			dec_pc <= '0;
		end else if (load) begin
			if (skip) begin
				// Upper word moves down into slot 0
				dec0_inst <= resp1_inst;
				dec0_flags <= resp1_flags;
				dec_pc <= head_addr + ADDR_W'(FETCH_STRIDE / 2);
			end else begin
				dec0_inst <= resp0_inst;
				dec0_flags <= resp0_flags;
				dec_pc <= head_addr;
			end
			dec1_inst <= resp1_inst;
			dec1_flags <= resp1_flags;
		end
	end

	// Lock hides the beat, the register keeps it for later
	assign dec0_valid = dec0_valid_q && !dec_lock;
	assign dec1_valid = dec1_valid_q && !dec_lock;

endmodule

// File: fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
	input  logic                  iCLOCK,
	input  logic                  inRESET,
	input  logic                  redirect,
	input  fetch_pkg::addr_t      redirect_addr,
	// Instruction memory request
	output logic                  fetch_req,
	output fetch_pkg::addr_t      fetch_addr,
	input  logic                  fetch_stall,
	// Instruction memory response
	input  logic                  resp0_valid,
	input  fetch_pkg::inst_t      resp0_inst,
	input  fetch_pkg::mmu_flags_t resp0_flags,
	input  logic                  resp1_valid,
	input  fetch_pkg::inst_t      resp1_inst,
	input  fetch_pkg::mmu_flags_t resp1_flags,
	output logic                  resp_lock,
	// Decode side
	output logic                  dec0_valid,
	output fetch_pkg::inst_t      dec0_inst,
	output fetch_pkg::mmu_flags_t dec0_flags,
	output logic                  dec1_valid,
	output fetch_pkg::inst_t      dec1_inst,
	output fetch_pkg::mmu_flags_t dec1_flags,
	output fetch_pkg::addr_t      dec_pc,
	input  logic                  dec_lock
);
	import fetch_pkg::*;

	logic  push;
	logic  pop;
	logic  queue_full;
	addr_t head_addr;

	// Memory holds its response whenever decode is stalled
	assign resp_lock = dec_lock;

	fetch_pc_gen u_pc_gen (
		.iCLOCK        (iCLOCK),
		.inRESET       (inRESET),
		.redirect      (redirect),
		.redirect_addr (redirect_addr),
		.fetch_stall   (fetch_stall),
		.queue_full    (queue_full),
		.fetch_req     (fetch_req),
		.fetch_addr    (fetch_addr),
		.push          (push)
	);

	fetch_addr_queue #(
		.payload_t (addr_t)
	) u_addr_queue (
		.iCLOCK    (iCLOCK),
		.inRESET   (inRESET),
		.flush     (redirect),   // Outstanding responses are dropped on redirect
		.push      (push),
		.push_data (fetch_addr),
		.pop       (pop),
		.head_data (head_addr),
		.full      (queue_full),
		.empty     ()
	);

	fetch_align u_align (
		.iCLOCK        (iCLOCK),
		.inRESET       (inRESET),
		.redirect      (redirect),
		.redirect_addr (redirect_addr),
		.resp0_valid   (resp0_valid),
		.resp1_valid   (resp1_valid),
		.resp0_inst    (resp0_inst),
		.resp1_inst    (resp1_inst),
		.resp0_flags   (resp0_flags),
		.resp1_flags   (resp1_flags),
		.head_addr     (head_addr),
		.dec_lock      (dec_lock),
		.pop           (pop),
		.dec0_valid    (dec0_valid),
		.dec1_valid    (dec1_valid),
		.dec0_inst     (dec0_inst),
		.dec1_inst     (dec1_inst),
		.dec0_flags    (dec0_flags),
		.dec1_flags    (dec1_flags),
		.dec_pc        (dec_pc)
	);

endmodule

// File: fetch_unit_sva.sv
`timescale 1ns/1ps

module fetch_unit_sva (
	input logic             iCLOCK,
	input logic             inRESET,
	input logic             redirect,
	input logic             fetch_req,
	input fetch_pkg::addr_t fetch_addr,
	input logic             fetch_stall,
	input logic             dec_lock,
	input logic             dec0_valid,
	input logic             dec1_valid
);
	import fetch_pkg::*;

	int sva_errors = 0;

	a_no_req_in_reset: assert property (@(posedge iCLOCK) !inRESET |-> !fetch_req)
		else begin
			$error("fetch_req high while reset is held");
			sva_errors++;
		end

	// Request drops in the redirect cycle
	a_no_req_on_redirect: assert property (
		@(posedge iCLOCK) disable iff (!inRESET) redirect |-> !fetch_req)
		else begin
			$error("fetch_req high in a redirect cycle");
			sva_errors++;
		end

	a_addr_held_on_stall: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		(fetch_stall && !redirect) |=> $stable(fetch_addr))
		else begin
			$error("fetch_addr moved while memory stalled");
			sva_errors++;
		end

	a_valid_low_on_lock: assert property (
		@(posedge iCLOCK) disable iff (!inRESET) dec_lock |-> !(dec0_valid || dec1_valid))
		else begin
			$error("decode valid high while dec_lock is set");
			sva_errors++;
		end

endmodule

// File: fetch_checker.sv
`timescale 1ns/1ps

module fetch_checker (
	input  logic                  iCLOCK,
	input  logic                  inRESET,
	input  logic                  redirect,
	input  fetch_pkg::addr_t      redirect_addr,
	input  logic                  fetch_req,
	input  fetch_pkg::addr_t      fetch_addr,
	input  logic                  resp_lock,
	input  logic                  dec_lock,
	input  logic                  dec0_valid,
	input  fetch_pkg::inst_t      dec0_inst,
	input  fetch_pkg::mmu_flags_t dec0_flags,
	input  logic                  dec1_valid,
	input  fetch_pkg::inst_t      dec1_inst,
	input  fetch_pkg::mmu_flags_t dec1_flags,
	input  fetch_pkg::addr_t      dec_pc,
	output int                    fetch_errors,
	output int                    beat_errors,
	output int                    beats,
	output int                    skip_beats
);
	import fetch_pkg::*;

	addr_t exp_fetch;   // Next address memory should accept
	addr_t exp_pc;      // Next instruction decode should see
	logic  exp_skip;
	int    fetch_err_cnt = 0;
	int    beat_err_cnt = 0;
	int    beat_cnt = 0;
	int    skip_cnt = 0;

	assign fetch_errors = fetch_err_cnt;
	assign beat_errors = beat_err_cnt;
	assign beats = beat_cnt;
	assign skip_beats = skip_cnt;

	function automatic inst_t word_at(input addr_t a);
		return a ^ 32'h5a5a_0000;
	endfunction

	function automatic mmu_flags_t flags_at(input addr_t a);
		return a[7:2];
	endfunction

	task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
			beat_err_cnt++;
		end
	endtask

	always @(posedge iCLOCK) begin
		if (!inRESET) begin
			exp_fetch = '0;   // Boot address
			exp_pc = '0;
			exp_skip = 1'b0;
		end else begin
			// Memory hold follows the decode stall
			compare("resp_lock", 32'(resp_lock), 32'(dec_lock));
			if (fetch_req) begin
				if (fetch_addr !== exp_fetch) begin
					$display("[ERROR] %0t ns: fetch_addr is %h, expected %h",
						$time, fetch_addr, exp_fetch);
					fetch_err_cnt++;
				end
				exp_fetch = exp_fetch + 32'd8;
			end
			if (dec_lock) begin
				compare("dec0_valid under lock", 32'(dec0_valid), 32'd0);
				compare("dec1_valid under lock", 32'(dec1_valid), 32'd0);
			end
			if (dec1_valid && !dec0_valid) begin
				compare("dec0_valid with dec1_valid set", 32'(dec0_valid), 32'd1);
			end
			if (dec0_valid) begin
				beat_cnt++;
				compare("dec_pc", dec_pc, exp_pc);
				compare("dec0_inst", dec0_inst, word_at(exp_pc));
				compare("dec0_flags", 32'(dec0_flags), 32'(flags_at(exp_pc)));
				if (exp_skip) begin
					// Only the upper word of the group is delivered
					compare("dec1_valid on skip beat", 32'(dec1_valid), 32'd0);
					skip_cnt++;
					exp_skip = 1'b0;
					exp_pc = exp_pc + 32'd4;
				end else begin
					compare("dec1_valid", 32'(dec1_valid), 32'd1);
					compare("dec1_inst", dec1_inst, word_at(exp_pc + 32'd4));
					compare("dec1_flags", 32'(dec1_flags), 32'(flags_at(exp_pc + 32'd4)));
					exp_pc = exp_pc + 32'd8;
				end
			end
			if (redirect) begin
				exp_fetch = {redirect_addr[ADDR_W-1:3], 3'b000};
				exp_pc = redirect_addr;
				exp_skip = redirect_addr[2];
			end
		end
	end

endmodule

// File: tb_fetch_unit.sv
`timescale 1ns/1ps

module tb_fetch_unit;
	import fetch_pkg::*;

	localparam int CLK_HALF     = 50;
	localparam int DRIVE_DELAY  = 1;
	localparam int RESET_CYCLES = 8;
	localparam int TARGET_BEATS = 600;
	localparam int MAX_CYCLES   = 20000;

	logic       iCLOCK;
	logic       inRESET;
	logic       redirect;
	addr_t      redirect_addr;
	logic       fetch_req;
	addr_t      fetch_addr;
	logic       fetch_stall;
	logic       resp0_valid;
	inst_t      resp0_inst;
	mmu_flags_t resp0_flags;
	logic       resp1_valid;
	inst_t      resp1_inst;
	mmu_flags_t resp1_flags;
	logic       resp_lock;
	logic       dec0_valid;
	inst_t      dec0_inst;
	mmu_flags_t dec0_flags;
	logic       dec1_valid;
	inst_t      dec1_inst;
	mmu_flags_t dec1_flags;
	addr_t      dec_pc;
	logic       dec_lock;

	logic [31:0] lfsr;
	addr_t       mem_addr_q[$];   // Accepted groups, oldest first
	int          mem_ready_q[$];  // Cycle from which each group may return
	int          cyc;
	int          run_cycles;
	logic        timed_out;
	int          fetch_errors;
	int          beat_errors;
	int          beats;
	int          skip_beats;
	int          total_errors;

	initial iCLOCK = 1'b0;
	always #CLK_HALF iCLOCK = ~iCLOCK;

	fetch_unit u_fetch_unit (.*);

	bind fetch_unit fetch_unit_sva u_sva (
		.iCLOCK      (iCLOCK),
		.inRESET     (inRESET),
		.redirect    (redirect),
		.fetch_req   (fetch_req),
		.fetch_addr  (fetch_addr),
		.fetch_stall (fetch_stall),
		.dec_lock    (dec_lock),
		.dec0_valid  (dec0_valid),
		.dec1_valid  (dec1_valid)
	);

	fetch_checker u_checker (.*);

	// Right shift Galois form, taps 32 30 26 25
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'hA300_0000;
		end
		return s >> 1;
	endfunction

	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
		return v;
	endfunction

	function automatic inst_t word_at(input addr_t a);
		return a ^ 32'h5a5a_0000;
	endfunction

	function automatic mmu_flags_t flags_at(input addr_t a);
		return a[7:2];
	endfunction

	// Memory side bookkeeping at the clock edge
	task automatic memory_edge();
		logic [31:0] lat;
		if (redirect) begin
			mem_addr_q.delete();   // Outstanding groups never come back
			mem_ready_q.delete();
		end else begin
			if (resp0_valid && !resp_lock) begin
				void'(mem_addr_q.pop_front());
				void'(mem_ready_q.pop_front());
			end
			if (fetch_req) begin
				lat = random_bits(2);
				mem_addr_q.push_back(fetch_addr);
				mem_ready_q.push_back(cyc + int'(lat));
			end
		end
	endtask

	task automatic drive_inputs();
		logic [31:0] r;
		addr_t       a;
		fetch_stall = (random_bits(2) == 0);
		dec_lock = (random_bits(2) == 0);
		if (!redirect && random_bits(5) == 0) begin
			r = random_bits(10);
			redirect = 1'b1;
			redirect_addr = {20'd0, r[9:0], 2'b00};
		end else begin
			redirect = 1'b0;
		end
		if (mem_addr_q.size() > 0 && mem_ready_q[0] <= cyc) begin
			a = mem_addr_q[0];
			resp0_valid = 1'b1;
			resp0_inst = word_at(a);
			resp0_flags = flags_at(a);
			resp1_valid = 1'b1;
			resp1_inst = word_at(a + 32'd4);
			resp1_flags = flags_at(a + 32'd4);
		end else begin
			resp0_valid = 1'b0;
			resp1_valid = 1'b0;
		end
	endtask

	initial begin
		lfsr = 32'h2ba147d7;
		cyc = 0;
		run_cycles = 0;
		timed_out = 1'b0;
		inRESET = 1'b0;
		redirect = 1'b0;
		redirect_addr = '0;
		fetch_stall = 1'b0;
		dec_lock = 1'b0;
		resp0_valid = 1'b0;
		resp0_inst = '0;
		resp0_flags = '0;
		resp1_valid = 1'b0;
		resp1_inst = '0;
		resp1_flags = '0;
		repeat (RESET_CYCLES) @(posedge iCLOCK);
		#DRIVE_DELAY inRESET = 1'b1;
		while (beats < TARGET_BEATS && !timed_out) begin
			@(posedge iCLOCK);
			cyc++;
			memory_edge();
			#DRIVE_DELAY;
			drive_inputs();
			run_cycles++;
			if (run_cycles >= MAX_CYCLES) begin
				timed_out = 1'b1;
			end
		end
		total_errors = fetch_errors + beat_errors + u_fetch_unit.u_sva.sva_errors;
		if (timed_out) begin
			$display("Timeout: only %0d of %0d decode beats arrived within %0d cycles",
				beats, TARGET_BEATS, MAX_CYCLES);
		end
		if (skip_beats == 0) begin
			$display("No skip beat was seen after a redirect into an upper word");
		end
		$display("fetch_errors=%0d beat_errors=%0d sva_errors=%0d beats=%0d skip_beats=%0d",
			fetch_errors, beat_errors, u_fetch_unit.u_sva.sva_errors, beats, skip_beats);
		if (!timed_out && total_errors == 0 && skip_beats > 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// File: src.f
fetch_pkg.sv
fetch_addr_queue.sv
fetch_pc_gen.sv
fetch_align.sv
fetch_unit.sv
fetch_unit_sva.sv
fetch_checker.sv
tb_fetch_unit.sv

// File: Bender.yml
package:
  name: fetch_unit

sources:
  - fetch_pkg.sv
  - fetch_addr_queue.sv
  - fetch_pc_gen.sv
  - fetch_align.sv
  - fetch_unit.sv
  - target: test
    files:
      - fetch_unit_sva.sv
      - fetch_checker.sv
      - tb_fetch_unit.sv
